//--- include/heap_defines.svh
// ----------------------------------------------------------------------
// heap geometry
// array count, elements per array and element width
// ----------------------------------------------------------------------
`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// width of an array number, 4 arrays
`define HEAP_ADDR_BITS 2

// width of an element index, 8 elements per array
`define HEAP_INDEX_BITS 3

// element width
`define HEAP_DATA_BITS 12

`endif

//--- rtl/arraySlot.sv
// ----------------------------------------------------------------------
// array slot
// one array's elements and size; runs element commands with
// bounds, full and empty checks
// ----------------------------------------------------------------------
`include "heap_defines.svh"

module arraySlot (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::heapCmd_t    slotCmd,
  input  logic                 select,
  output heapPkg::slotResult_t result,
  output logic                 resultValid
);

  logic [`HEAP_DATA_BITS-1:0]  elements [heapPkg::ARRAY_LENGTH];
  logic [`HEAP_INDEX_BITS:0]   size;       // 0 .. ARRAY_LENGTH

  logic [`HEAP_DATA_BITS-1:0]  element;
  logic [`HEAP_DATA_BITS-1:0]  aluValue;
  logic [`HEAP_DATA_BITS-1:0]  nextValue;
  logic [`HEAP_DATA_BITS-1:0]  outData;
  heapPkg::heapError_e         outError;
  logic [`HEAP_INDEX_BITS:0]   nextSize;
  logic [`HEAP_INDEX_BITS-1:0] writeIndex;
  logic [`HEAP_INDEX_BITS-1:0] topIndex;
  logic                        writeEnable;
  logic                        inBounds;

  assign element  = elements[slotCmd.index];
  assign inBounds = {1'b0, slotCmd.index} < size;
  assign topIndex = size[`HEAP_INDEX_BITS-1:0] - 1'b1;  // last live element

  // element update, wraps at data width
  always_comb begin
    case (slotCmd.op)
      heapPkg::opAdd:      aluValue = element + slotCmd.data;
      heapPkg::opSubtract: aluValue = element - slotCmd.data;
      heapPkg::opOr:       aluValue = element | slotCmd.data;
      heapPkg::opXor:      aluValue = element ^ slotCmd.data;
      default:             aluValue = element & slotCmd.data;
    endcase
  end

  // ---------------------------------------------------------------------
  // command execution; errors leave memory and size alone
  // ---------------------------------------------------------------------
  always_comb begin
    nextSize    = size;
    writeEnable = 1'b0;
    writeIndex  = slotCmd.index;
    nextValue   = slotCmd.data;
    outData     = '0;
    outError    = heapPkg::errNone;
    case (slotCmd.op)
      heapPkg::opAlloc: nextSize = '0;           // fresh array
      heapPkg::opWrite: begin
        writeEnable = 1'b1;
        outData     = slotCmd.data;
        if (!inBounds) nextSize = {1'b0, slotCmd.index} + 1'b1;  // grow to index+1
      end
      heapPkg::opRead: begin
        if (inBounds) outData  = element;
        else          outError = heapPkg::errOutOfBounds;
      end
      heapPkg::opSize: outData = {{(`HEAP_DATA_BITS-`HEAP_INDEX_BITS-1){1'b0}}, size};
      heapPkg::opPush: begin
        if (size == heapPkg::ARRAY_LENGTH) begin
          outError = heapPkg::errFull;
        end else begin
          writeEnable = 1'b1;
          writeIndex  = size[`HEAP_INDEX_BITS-1:0];
          nextSize    = size + 1'b1;
          outData     = slotCmd.data;
        end
      end
      heapPkg::opPop: begin
        if (size == '0) begin
          outError = heapPkg::errEmpty;
        end else begin
          nextSize = size - 1'b1;
          outData  = elements[topIndex];       // removed element
        end
      end
      heapPkg::opAdd, heapPkg::opSubtract, heapPkg::opOr,
      heapPkg::opXor, heapPkg::opAnd: begin
        if (!inBounds) begin
          outError = heapPkg::errOutOfBounds;
        end else begin
          writeEnable = 1'b1;
          nextValue   = aluValue;
          outData     = aluValue;              // new value back
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      size        <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= select;
      if (select) size <= nextSize;
    end
  end

  always_ff @(posedge clock) begin
    if (select && writeEnable) elements[writeIndex] <= nextValue;
    result.data  <= outData;
    result.error <= outError;
  end

  sizeBound: assert property (@(posedge clock) disable iff (!resetN)
    size <= heapPkg::ARRAY_LENGTH);

endmodule

//--- rtl/heapDecoder.sv
// ----------------------------------------------------------------------
// heap decoder
// registers requests, tracks allocation and the free stack, routes
// element commands to one slot and settles heap-level results itself
// ----------------------------------------------------------------------
`include "heap_defines.svh"

module heapDecoder (
  input  logic                         clock,
  input  logic                         resetN,
  input  logic                         request,
  input  heapPkg::heapCmd_t            cmd,
  output heapPkg::heapCmd_t            slotCmd,
  output logic [heapPkg::ARRAYS-1:0]   slotSelect,
  output heapPkg::slotResult_t         decodeResult,
  output logic                         decodeOwned,
  output logic                         decodeValid
);

  heapPkg::heapCmd_t                reqCmd;       // input stage
  logic                             reqValid;
  logic [`HEAP_ADDR_BITS:0]         highWater;    // arrays ever handed out
  logic [`HEAP_ADDR_BITS:0]         freeTop;      // free stack depth
  logic [heapPkg::ARRAYS-1:0]       allocated;
  logic [`HEAP_ADDR_BITS-1:0]       freeStack [heapPkg::ARRAYS];
  logic                             stageValid;   // slot stage
  logic                             stageOwned;
  heapPkg::slotResult_t             stageResult;

  logic [`HEAP_ADDR_BITS-1:0]       popIndex;
  logic [`HEAP_ADDR_BITS-1:0]       allocTarget;
  logic                             canPop;
  logic                             canGrow;
  logic                             freePush;
  heapPkg::heapError_e              checkError;
  heapPkg::heapCmd_t                routedCmd;
  heapPkg::slotResult_t             ownedResult;
  logic                             owned;
  logic [heapPkg::ARRAYS-1:0]       nextSelect;

  // ---------------------------------------------------------------------
  // allocation checks on the registered request
  // ---------------------------------------------------------------------
  assign popIndex    = freeTop[`HEAP_ADDR_BITS-1:0] - 1'b1;  // wraps right when full
  assign canPop      = freeTop != '0;
  assign canGrow     = highWater < heapPkg::ARRAYS;
  assign allocTarget = canPop ? freeStack[popIndex] : highWater[`HEAP_ADDR_BITS-1:0];

  always_comb begin
    checkError = heapPkg::errNone;
    if ({1'b0, reqCmd.array} >= highWater) checkError = heapPkg::errNeverAllocated;
    else if (!allocated[reqCmd.array])     checkError = heapPkg::errFreed;
  end

  assign freePush = reqValid && reqCmd.op == heapPkg::opFree
                    && checkError == heapPkg::errNone;

  always_comb begin
    routedCmd         = reqCmd;
    owned             = 1'b1;                  // most heap-level ops end here
    nextSelect        = '0;
    ownedResult.data  = '0;
    ownedResult.error = heapPkg::errNone;
    case (reqCmd.op)
      heapPkg::opResetHeap: ownedResult.data = '0;
      heapPkg::opAlloc: begin
        if (canPop || canGrow) begin
          routedCmd.array         = allocTarget; // slot clears its size
          nextSelect[allocTarget] = 1'b1;
          ownedResult.data = {{(`HEAP_DATA_BITS-`HEAP_ADDR_BITS){1'b0}}, allocTarget};
        end else begin
          ownedResult.error = heapPkg::errNoMemory;
        end
      end
      heapPkg::opFree: ownedResult.error = checkError;  // covers double free
      default: begin
        if (checkError != heapPkg::errNone) begin
          ownedResult.error = checkError;
        end else begin
          owned                     = 1'b0;      // slot answers
          nextSelect[reqCmd.array]  = 1'b1;
        end
      end
    endcase
  end

  // ---------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      reqValid    <= 1'b0;
      highWater   <= '0;
      freeTop     <= '0;
      allocated   <= '0;
      slotSelect  <= '0;
      stageValid  <= 1'b0;
      stageOwned  <= 1'b0;
      decodeOwned <= 1'b0;
      decodeValid <= 1'b0;
    end else begin
      reqValid    <= request;
      stageValid  <= reqValid;
      stageOwned  <= reqValid && owned;
      slotSelect  <= reqValid ? nextSelect : '0;
      decodeValid <= stageValid;                // lines up with slot results
      decodeOwned <= stageValid && stageOwned;
      if (reqValid) begin
        case (reqCmd.op)
          heapPkg::opResetHeap: begin
            highWater <= '0;
            freeTop   <= '0;
            allocated <= '0;
          end
          heapPkg::opAlloc: begin
            if (canPop) freeTop <= freeTop - 1'b1;      // reuse first
            else if (canGrow) highWater <= highWater + 1'b1;
            if (canPop || canGrow) allocated[allocTarget] <= 1'b1;
          end
          heapPkg::opFree: begin
            if (freePush) begin
              freeTop                  <= freeTop + 1'b1;
              allocated[reqCmd.array]  <= 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    reqCmd       <= cmd;
    slotCmd      <= routedCmd;
    stageResult  <= ownedResult;
    decodeResult <= stageResult;
    if (freePush) freeStack[freeTop[`HEAP_ADDR_BITS-1:0]] <= reqCmd.array;
  end

  // one slot at most works on a command and it holds an allocated array
  selectOneHot: assert property (@(posedge clock) disable iff (!resetN)
    $onehot0(slotSelect) && (slotSelect & ~allocated) == '0);
  // rejecting a double free keeps the stack within ARRAYS
  freeStackBound: assert property (@(posedge clock) disable iff (!resetN)
    freeTop <= heapPkg::ARRAYS);

endmodule

//--- rtl/heapPkg.sv
// ----------------------------------------------------------------------
// heap types
// opcodes, error codes, command and result words
// ----------------------------------------------------------------------
`include "heap_defines.svh"

package heapPkg;

  localparam int ARRAYS       = 1 << `HEAP_ADDR_BITS;   // arrays in the heap
  localparam int ARRAY_LENGTH = 1 << `HEAP_INDEX_BITS;  // elements per array

  // command opcodes
  typedef enum logic [3:0] {
    opResetHeap = 4'h0,  // forget every allocation
    opAlloc     = 4'h1,
    opFree      = 4'h2,
    opWrite     = 4'h3,
    opRead      = 4'h4,
    opSize      = 4'h5,
    opPush      = 4'h6,
    opPop       = 4'h7,
    opAdd       = 4'h8,  // element updates return the new value
    opSubtract  = 4'h9,
    opOr        = 4'ha,
    opXor       = 4'hb,
    opAnd       = 4'hc
  } heapOp_e;

  typedef enum logic [2:0] {
    errNone           = 3'd0,
    errNeverAllocated = 3'd1,  // at or above high-water count
    errFreed          = 3'd2,  // freed, incl. double free
    errOutOfBounds    = 3'd3,
    errFull           = 3'd4,
    errEmpty          = 3'd5,
    errNoMemory       = 3'd6   // no array left to allocate
  } heapError_e;

  // ---------------------------------------------------------------------
  typedef struct packed {
    heapOp_e                     op;
    logic [`HEAP_ADDR_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0] index;
    logic [`HEAP_DATA_BITS-1:0]  data;
  } heapCmd_t;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0] data;
    heapError_e                 error;
  } slotResult_t;

endpackage

//--- rtl/heapTop.sv
// ----------------------------------------------------------------------
// heap top level
// decoder, one slot per array and the output selector
// ----------------------------------------------------------------------
`include "heap_defines.svh"

module heapTop (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       request,
  input  heapPkg::heapCmd_t          cmd,
  output logic [`HEAP_DATA_BITS-1:0] out,
  output heapPkg::heapError_e        error,
  output logic                       done
);

  heapPkg::heapCmd_t          slotCmd;
  logic [heapPkg::ARRAYS-1:0] slotSelect;
  heapPkg::slotResult_t       decodeResult;
  logic                       decodeOwned;
  logic                       decodeValid;
  heapPkg::slotResult_t       slotResults [heapPkg::ARRAYS];
  logic [heapPkg::ARRAYS-1:0] slotValid;

  heapDecoder decoder_i (
    .clock        (clock),
    .resetN       (resetN),
    .request      (request),
    .cmd          (cmd),
    .slotCmd      (slotCmd),
    .slotSelect   (slotSelect),
    .decodeResult (decodeResult),
    .decodeOwned  (decodeOwned),
    .decodeValid  (decodeValid)
  );

  for (genvar g = 0; g < heapPkg::ARRAYS; g++) begin : slot_g
    arraySlot slot_i (
      .clock       (clock),
      .resetN      (resetN),
      .slotCmd     (slotCmd),
      .select      (slotSelect[g]),
      .result      (slotResults[g]),
      .resultValid (slotValid[g])
    );
  end

  resultSelect select_i (
    .decodeResult (decodeResult),
    .decodeOwned  (decodeOwned),
    .decodeValid  (decodeValid),
    .slotResults  (slotResults),
    .slotValid    (slotValid),
    .out          (out),
    .error        (error),
    .done         (done)
  );

endmodule

//--- rtl/resultSelect.sv
// ----------------------------------------------------------------------
// result selector
// picks the decoder or the active slot result for the outputs
// ----------------------------------------------------------------------
`include "heap_defines.svh"

module resultSelect (
  input  heapPkg::slotResult_t       decodeResult,
  input  logic                       decodeOwned,
  input  logic                       decodeValid,
  input  heapPkg::slotResult_t       slotResults [heapPkg::ARRAYS],
  input  logic [heapPkg::ARRAYS-1:0] slotValid,
  output logic [`HEAP_DATA_BITS-1:0] out,
  output heapPkg::heapError_e        error,
  output logic                       done
);

  heapPkg::slotResult_t picked;

  always_comb begin
    picked = decodeResult;               // heap-level ops and alloc errors
    if (!decodeOwned) begin
      picked.data  = '0;
      picked.error = heapPkg::errNone;
      for (int i = 0; i < heapPkg::ARRAYS; i++) begin
        if (slotValid[i]) picked = slotResults[i];
      end
    end
  end

  assign out   = picked.data;
  assign error = picked.error;
  assign done  = decodeValid;           // stage-two valid from the decoder

  // decoder routes each command to one slot at most
  always_comb begin
    if (!$isunknown(slotValid)) assert final ($onehot0(slotValid));
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the heap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module heapTb -Mdir obj_dir -o heapSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/heapSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- src.f
+incdir+include
rtl/heapPkg.sv
rtl/heapDecoder.sv
rtl/arraySlot.sv
rtl/resultSelect.sv
rtl/heapTop.sv
verif/clockGen.sv
verif/heapTb.sv

//--- verif/clockGen.sv
// ----------------------------------------------------------------------
// testbench clock and reset
// period 10 clock, active-low reset held for 8 cycles
// ----------------------------------------------------------------------
module clockGen (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // period 10
  end

  initial begin
    resetN = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);           // release away from the active edge
    resetN = 1'b1;
  end

endmodule

//--- verif/heapTb.sv
// ----------------------------------------------------------------------
// heap testbench
// replays the command file twice, first with random gaps and then
// back to back, and checks every result against the file
// ----------------------------------------------------------------------
`include "heap_defines.svh"

module heapTb;

  localparam int LATENCY = 2;  // request edge to done, in cycles

  logic                       clock;
  logic                       resetN;
  logic                       request;
  heapPkg::heapCmd_t          cmd;
  logic [`HEAP_DATA_BITS-1:0] out;
  heapPkg::heapError_e        error;
  logic                       done;

  // commands and expectations from the file
  heapPkg::heapCmd_t          cmdList [$];
  logic [`HEAP_DATA_BITS-1:0] outList [$];
  heapPkg::heapError_e        errList [$];

  // expectations of commands in flight
  logic [`HEAP_DATA_BITS-1:0] pendData [$];
  heapPkg::heapError_e        pendError [$];
  int                         pendCycle [$];  // cycle count when done is due

  int completed  = 0;
  int cycleCount = 0;
  int cycleLimit = 0;         // set once the file is read

  clockGen clock_i (
    .clock  (clock),
    .resetN (resetN)
  );

  heapTop dut_i (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .cmd     (cmd),
    .out     (out),
    .error   (error),
    .done    (done)
  );

  // ---------------------------------------------------------------------
  // failure and compare tasks
  // ---------------------------------------------------------------------
  task automatic stopOnError(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkData(input logic [`HEAP_DATA_BITS-1:0] expected);
    if (out !== expected)
      stopOnError($sformatf("Mismatch out: got 0x%03h, expected 0x%03h (result %0d)",
                            out, expected, completed));
  endtask

  task automatic checkError(input heapPkg::heapError_e expected);
    if (error !== expected)
      stopOnError($sformatf("Mismatch error: got 0x%0h, expected 0x%0h (result %0d)",
                            error, expected, completed));
  endtask

  // ---------------------------------------------------------------------
  // command file with // comment lines
  // ---------------------------------------------------------------------
  task automatic loadCommands();
    int                fd;
    int                fields;
    string             line;
    logic [31:0]       fOp, fArray, fIndex, fData, fOut, fErr;
    heapPkg::heapCmd_t c;
    fd = $fopen("verif/heap_input.txt", "r");
    if (fd == 0) stopOnError("could not open the command file verif/heap_input.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 1) == "//") continue;  // blank or comment
      fields = $sscanf(line, "%h %h %h %h %h %h", fOp, fArray, fIndex, fData, fOut, fErr);
      if (fields != 6) stopOnError($sformatf("command file line is malformed: %s", line));
      c.op    = heapPkg::heapOp_e'(fOp[3:0]);
      c.array = fArray[`HEAP_ADDR_BITS-1:0];
      c.index = fIndex[`HEAP_INDEX_BITS-1:0];
      c.data  = fData[`HEAP_DATA_BITS-1:0];
      cmdList.push_back(c);
      outList.push_back(fOut[`HEAP_DATA_BITS-1:0]);
      errList.push_back(heapPkg::heapError_e'(fErr[2:0]));
    end
    $fclose(fd);
    if (cmdList.size() == 0) stopOnError("the command file holds no commands");
  endtask

  // one-cycle strobe driven just after a falling edge
  task automatic issueCommand(input int n);
    request = 1'b1;
    cmd     = cmdList[n];
    pendData.push_back(outList[n]);
    pendError.push_back(errList[n]);
    pendCycle.push_back(cycleCount + 1 + LATENCY);  // sampled at the next rising edge
    @(negedge clock);
    request = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  initial begin : stimulus
    int idle;
    void'($urandom(32'h32a3_944c));
    request = 1'b0;
    cmd     = '0;
    loadCommands();
    cycleLimit = 4 * cmdList.size() + 40;  // two passes with gaps of up to 2
    @(posedge resetN);
    @(negedge clock);
    // pass one with random idle cycles
    for (int i = 0; i < cmdList.size(); i++) begin
      issueCommand(i);
      idle = int'($urandom % 3);
      repeat (idle) @(negedge clock);
    end
    // pass two back to back with the same expectations
    for (int i = 0; i < cmdList.size(); i++) begin
      issueCommand(i);
    end
    repeat (LATENCY + 2) @(negedge clock);  // last result and any stray done
    if (pendData.size() != 0) begin
      stopOnError($sformatf("%0d of %0d results never arrived",
                            pendData.size(), 2 * cmdList.size()));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // results are stable around the falling edge
  always @(negedge clock) begin : resultMonitor
    int dueCycle;
    if (resetN === 1'b1 && $isunknown(done))
      stopOnError("done is unknown after reset");
    if (resetN === 1'b1 && done === 1'b1) begin
      if (pendData.size() == 0) begin
        stopOnError("done pulsed with no command outstanding");
      end else begin
        dueCycle = pendCycle.pop_front();
        if (cycleCount != dueCycle)
          stopOnError($sformatf("result %0d arrived in cycle %0d instead of cycle %0d",
                                completed, cycleCount, dueCycle));
        checkData(pendData.pop_front());
        checkError(pendError.pop_front());
        completed++;
      end
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit)
      stopOnError($sformatf("timeout after %0d cycles with %0d results outstanding",
                            cycleCount, pendData.size()));
  end

endmodule

//--- verif/heap_input.txt
// columns: op array index data expected-out expected-error, all hex
// op 0 ResetHeap .. c And; error 0 none, 1 never, 2 freed, 3 bounds, 4 full, 5 empty, 6 memory
0 0 0 000 000 0  // reset heap
4 0 0 000 000 1  // nothing allocated yet
1 0 0 000 000 0
1 0 0 000 001 0
4 2 0 000 000 1  // above high-water
1 0 0 000 002 0
1 0 0 000 003 0
1 0 0 000 000 6  // all four in use
2 1 0 000 000 0
4 1 0 000 000 2  // freed array
2 1 0 000 000 2  // double free
1 0 0 000 001 0  // reuse from free stack
3 1 2 abc abc 0
5 1 0 000 003 0
4 1 2 000 abc 0
4 1 5 000 000 3
6 2 0 101 101 0
6 2 0 102 102 0
6 2 0 103 103 0
6 2 0 104 104 0
6 2 0 105 105 0
6 2 0 106 106 0
6 2 0 107 107 0
6 2 0 108 108 0
6 2 0 109 000 4  // full
5 2 0 000 008 0
7 2 0 000 108 0
7 2 0 000 107 0
7 2 0 000 106 0
7 2 0 000 105 0
7 2 0 000 104 0
7 2 0 000 103 0
7 2 0 000 102 0
7 2 0 000 101 0
7 2 0 000 000 5  // empty
3 3 0 ffe ffe 0
8 3 0 005 003 0  // add wraps
9 3 0 004 fff 0  // subtract wraps
c 3 0 0f0 0f0 0
a 3 0 00f 0ff 0
b 3 0 0aa 055 0
4 3 0 000 055 0
8 3 1 001 000 3  // past size
